// File: fpu_config.svh
/* fpu issue slice
   configuration */
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// operand and result width
`define FPU_WORD_W 64

// result buses visible to the forwarders
`define FPU_NBUS 4

// forward select width, see fwd_src_t
`define FPU_SEL_W 4

// instruction tag carried to the exception report
`define FPU_TAG_W 6

// invalid-enable bit in fpcsr
`define FPU_CSR_INV_EN 0

// issue edge to result visible, in cycles
`define FPU_LAT 2

`endif

// File: fpu_pkg.sv
/* fpu slice types */
`default_nettype none

`include "fpu_config.svh"

package fpu_pkg;

  typedef struct packed {
    logic        sign;
    logic [10:0] exp;
    logic [51:0] man;
  } fp_dbl_t;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] man;
  } fp_sng_t;

  // one word, read as a double or as two singles (lane 0 low)
  typedef union packed {
    fp_dbl_t       d;
    fp_sng_t [1:0] s;
  } fp_word_t;

  typedef enum logic [2:0] {
    ALU_AND, ALU_OR, ALU_XOR, ALU_ANDN, ALU_CMP_D, ALU_CMP_SP
  } alu_op_t;

  typedef enum logic [1:0] {
    PERM_MERGE, PERM_SWAP, PERM_DUP, PERM_MOVB
  } perm_op_t;

  // unlisted codes fall back to the issue operand
  typedef enum logic [`FPU_SEL_W-1:0] {
    FWD_ISSUE = 4'd0,
    FWD_BUS0 = 4'd1, FWD_BUS1 = 4'd2, FWD_BUS2 = 4'd3, FWD_BUS3 = 4'd4,
    FWD_DLY0 = 4'd5, FWD_DLY1 = 4'd6, FWD_DLY2 = 4'd7, FWD_DLY3 = 4'd8
  } fwd_src_t;

endpackage

`default_nettype wire

// File: operand_forward.sv
/* operand forwarding mux */
`timescale 1ns/1ps
`default_nettype none

`include "fpu_config.svh"

module operand_forward (
  input  logic                                   clk,
  input  logic                                   rst,
  input  fpu_pkg::fwd_src_t                      sel,
  input  logic [`FPU_WORD_W-1:0]                 issue_val,
  input  logic [`FPU_NBUS-1:0][`FPU_WORD_W-1:0]  bus,
  input  logic                                   bus_now,
  output logic [`FPU_WORD_W-1:0]                 opnd
);

  logic [`FPU_NBUS-1:0][`FPU_WORD_W-1:0] bus_dly;
  logic                                  dly_vld;
  logic [1:0]                            bus_idx;

  // bus one edge before the issue sample
  always_ff @(posedge clk) begin
    bus_dly <= bus;
  end

  // delayed copy only holds real data once a live sample went through
  always_ff @(posedge clk) begin
    if (rst) begin
      dly_vld <= 1'b0;
    end else begin
      dly_vld <= bus_now;
    end
  end

  // codes 1..4 and 5..8 both map bus n to low bits n+1
  assign bus_idx = sel[1:0] - 2'd1;

  always_comb begin
    opnd = issue_val;
    if (sel >= fpu_pkg::FWD_BUS0 && sel <= fpu_pkg::FWD_BUS3) begin
      if (bus_now) begin
        opnd = bus[bus_idx];
      end
    end else if (sel >= fpu_pkg::FWD_DLY0 && sel <= fpu_pkg::FWD_DLY3) begin
      if (dly_vld) begin
        opnd = bus_dly[bus_idx];
      end
    end
  end

endmodule

`default_nettype wire

// File: fp_logic_cmp.sv
/* port 0 logic and compare */
`timescale 1ns/1ps
`default_nettype none

`include "fpu_config.svh"

module fp_logic_cmp (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   en,
  input  fpu_pkg::alu_op_t       op,
  input  fpu_pkg::fp_word_t      a,
  input  fpu_pkg::fp_word_t      b,
  output logic [`FPU_WORD_W-1:0] res,
  output logic [3:0]             flags,
  output logic                   invalid,
  output logic                   valid
);

  logic [`FPU_WORD_W-1:0] res_c;
  logic [3:0]             flags_c;
  logic                   inv_c;
  logic                   nan_d;
  logic [1:0]             ord_d;
  logic [1:0]             nan_s;
  logic [1:0][1:0]        ord_s;

  function automatic logic is_nan_d(fpu_pkg::fp_dbl_t x);
    return (&x.exp) && (|x.man);
  endfunction

  function automatic logic is_nan_s(fpu_pkg::fp_sng_t x);
    return (&x.exp) && (|x.man);
  endfunction

  // sign-magnitude order, returns {less, equal}; both zeros are equal
  function automatic logic [1:0] sm_order(logic sa, logic [62:0] ma,
                                          logic sb, logic [62:0] mb);
    logic eq;
    logic lt;
    eq = ((ma == '0) && (mb == '0)) || ((sa == sb) && (ma == mb));
    if (sa != sb) lt = sa;
    else if (sa) lt = ma > mb;
    else lt = ma < mb;
    return {lt & ~eq, eq};
  endfunction

  always_comb begin
    nan_d = is_nan_d(a.d) || is_nan_d(b.d);
    ord_d = sm_order(a.d.sign, {a.d.exp, a.d.man}, b.d.sign, {b.d.exp, b.d.man});
    for (int i = 0; i < 2; i++) begin
      nan_s[i] = is_nan_s(a.s[i]) || is_nan_s(b.s[i]);
      ord_s[i] = sm_order(a.s[i].sign, {32'd0, a.s[i].exp, a.s[i].man},
                          b.s[i].sign, {32'd0, b.s[i].exp, b.s[i].man});
    end
    res_c   = '0;
    flags_c = '0;
    inv_c   = 1'b0;
    case (op)
      fpu_pkg::ALU_AND:  res_c = a & b;
      fpu_pkg::ALU_OR:   res_c = a | b;
      fpu_pkg::ALU_XOR:  res_c = a ^ b;
      fpu_pkg::ALU_ANDN: res_c = a & ~b;
      fpu_pkg::ALU_CMP_D: begin
        // {unordered, less, equal, greater}
        flags_c = nan_d ? 4'b1000 : {1'b0, ord_d, ~|ord_d};
        inv_c   = nan_d;
      end
      fpu_pkg::ALU_CMP_SP: begin
        for (int i = 0; i < 2; i++) begin
          res_c[32*i +: 32] = {32{ord_s[i][1] & ~nan_s[i]}};
        end
        inv_c = |nan_s;
      end
      default: res_c = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else begin
      valid <= en;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      res     <= res_c;
      flags   <= flags_c;
      invalid <= inv_c;
    end
  end

endmodule

`default_nettype wire

// File: fp_perm.sv
/* port 1 lane permute */
`timescale 1ns/1ps
`default_nettype none

`include "fpu_config.svh"

module fp_perm (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   en,
  input  fpu_pkg::perm_op_t      op,
  input  logic [`FPU_WORD_W-1:0] a,
  input  logic [`FPU_WORD_W-1:0] b,
  output logic [`FPU_WORD_W-1:0] res,
  output logic                   valid
);

  localparam int LANE_W = `FPU_WORD_W / 2;

  logic [`FPU_WORD_W-1:0] perm_c;

  // lane 0 is the low half
  always_comb begin
    case (op)
      fpu_pkg::PERM_MERGE: perm_c = {b[`FPU_WORD_W-1:LANE_W], a[LANE_W-1:0]};
      fpu_pkg::PERM_SWAP:  perm_c = {a[LANE_W-1:0], a[`FPU_WORD_W-1:LANE_W]};
      fpu_pkg::PERM_DUP:   perm_c = {a[LANE_W-1:0], a[LANE_W-1:0]};
      default:             perm_c = b;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else begin
      valid <= en;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      res <= perm_c;
    end
  end

endmodule

`default_nettype wire

// File: fpu_excpt.sv
/* port 0 exception report */
`timescale 1ns/1ps
`default_nettype none

`include "fpu_config.svh"

module fpu_excpt (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  en,
  input  logic [`FPU_TAG_W-1:0] tag,
  input  logic                  invalid,
  input  logic                  inv_en,
  output logic                  exc_valid,
  output logic [`FPU_TAG_W-1:0] exc_tag
);

  logic v_q;
  logic inv_en_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      v_q <= 1'b0;
    end else begin
      v_q <= en;
    end
  end

  // same stage as the datapath result register
  always_ff @(posedge clk) begin
    exc_tag  <= tag;
    inv_en_q <= inv_en;
  end

  // invalid arrives already registered by fp_logic_cmp
  assign exc_valid = v_q & inv_en_q & invalid;

endmodule

`default_nettype wire

// File: fpu_slice.sv
/* two-port fpu issue slice */
`timescale 1ns/1ps
`default_nettype none

`include "fpu_config.svh"

module fpu_slice (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [31:0]                           fpcsr,
  input  logic                                  en0,
  input  fpu_pkg::alu_op_t                      op0,
  input  logic [`FPU_WORD_W-1:0]                a0,
  input  logic [`FPU_WORD_W-1:0]                b0,
  input  fpu_pkg::fwd_src_t                     sel_a0,
  input  fpu_pkg::fwd_src_t                     sel_b0,
  input  logic [`FPU_TAG_W-1:0]                 tag0,
  input  logic                                  en1,
  input  fpu_pkg::perm_op_t                     op1,
  input  logic [`FPU_WORD_W-1:0]                a1,
  input  logic [`FPU_WORD_W-1:0]                b1,
  input  fpu_pkg::fwd_src_t                     sel_a1,
  input  fpu_pkg::fwd_src_t                     sel_b1,
  input  logic [`FPU_NBUS-1:0][`FPU_WORD_W-1:0] fwd_bus,
  output logic [`FPU_WORD_W-1:0]                res0,
  output logic [3:0]                            res0_flags,
  output logic                                  res0_valid,
  output logic [`FPU_WORD_W-1:0]                res1,
  output logic                                  res1_valid,
  output logic                                  exc_valid,
  output logic [`FPU_TAG_W-1:0]                 exc_tag
);

  logic                                  en0_q, en1_q, bus_live;
  fpu_pkg::alu_op_t                      op0_q;
  fpu_pkg::perm_op_t                     op1_q;
  logic [`FPU_WORD_W-1:0]                a0_q, b0_q, a1_q, b1_q;
  fpu_pkg::fwd_src_t                     sel_a0_q, sel_b0_q, sel_a1_q, sel_b1_q;
  logic [`FPU_TAG_W-1:0]                 tag0_q;
  logic                                  inv_en_q;
  logic [`FPU_NBUS-1:0][`FPU_WORD_W-1:0] bus_q;
  logic [`FPU_WORD_W-1:0]                opnd_a0, opnd_b0, opnd_a1, opnd_b1;
  logic                                  invalid0;

  // issue edge; bus_live marks bus samples taken out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      en0_q    <= 1'b0;
      en1_q    <= 1'b0;
      bus_live <= 1'b0;
    end else begin
      en0_q    <= en0;
      en1_q    <= en1;
      bus_live <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    op0_q    <= op0;
    a0_q     <= a0;
    b0_q     <= b0;
    sel_a0_q <= sel_a0;
    sel_b0_q <= sel_b0;
    tag0_q   <= tag0;
    op1_q    <= op1;
    a1_q     <= a1;
    b1_q     <= b1;
    sel_a1_q <= sel_a1;
    sel_b1_q <= sel_b1;
    inv_en_q <= fpcsr[`FPU_CSR_INV_EN];
    bus_q    <= fwd_bus;
  end

  operand_forward u_fwd_a0 (.clk(clk), .rst(rst), .sel(sel_a0_q), .issue_val(a0_q),
                            .bus(bus_q), .bus_now(bus_live), .opnd(opnd_a0));
  operand_forward u_fwd_b0 (.clk(clk), .rst(rst), .sel(sel_b0_q), .issue_val(b0_q),
                            .bus(bus_q), .bus_now(bus_live), .opnd(opnd_b0));
  operand_forward u_fwd_a1 (.clk(clk), .rst(rst), .sel(sel_a1_q), .issue_val(a1_q),
                            .bus(bus_q), .bus_now(bus_live), .opnd(opnd_a1));
  operand_forward u_fwd_b1 (.clk(clk), .rst(rst), .sel(sel_b1_q), .issue_val(b1_q),
                            .bus(bus_q), .bus_now(bus_live), .opnd(opnd_b1));

  fp_logic_cmp u_logic_cmp (.clk(clk), .rst(rst), .en(en0_q), .op(op0_q),
                            .a(opnd_a0), .b(opnd_b0), .res(res0), .flags(res0_flags),
                            .invalid(invalid0), .valid(res0_valid));

  fp_perm u_perm (.clk(clk), .rst(rst), .en(en1_q), .op(op1_q),
                  .a(opnd_a1), .b(opnd_b1), .res(res1), .valid(res1_valid));

  fpu_excpt u_excpt (.clk(clk), .rst(rst), .en(en0_q), .tag(tag0_q),
                     .invalid(invalid0), .inv_en(inv_en_q),
                     .exc_valid(exc_valid), .exc_tag(exc_tag));

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
/* testbench clock and reset */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int RST_CYCLES = 8
) (
  output logic clk,
  output logic rst
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // released 1 ns after the last reset edge, in step with the stimulus
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: fpu_chk.sv
/* fpu slice assertions */
`timescale 1ns/1ps
`default_nettype none

`include "fpu_config.svh"

module fpu_chk (
  input logic        clk,
  input logic        rst,
  input logic [31:0] fpcsr,
  input logic        en0,
  input logic        en1,
  input logic        res0_valid,
  input logic        res1_valid,
  input logic        exc_valid
);

  // a result needs its issue edge and the edge after it out of reset
  a_res0_lat: assert property (@(posedge clk) disable iff (rst)
    res0_valid == ($past(en0, `FPU_LAT) && !$past(rst, `FPU_LAT) && !$past(rst)))
    else $error("res0_valid does not follow en0 by the issue latency");

  a_res1_lat: assert property (@(posedge clk) disable iff (rst)
    res1_valid == ($past(en1, `FPU_LAT) && !$past(rst, `FPU_LAT) && !$past(rst)))
    else $error("res1_valid does not follow en1 by the issue latency");

  a_rst_quiet: assert property (@(posedge clk)
    rst |=> !res0_valid && !res1_valid && !exc_valid)
    else $error("a valid output is high while in reset");

  // exception report needs a port 0 result and the enable seen at issue
  a_exc_res0: assert property (@(posedge clk) disable iff (rst)
    exc_valid |-> res0_valid && $past(fpcsr[`FPU_CSR_INV_EN], `FPU_LAT))
    else $error("exc_valid without res0_valid or without invalid enable at issue");

endmodule

bind fpu_slice fpu_chk u_chk (
  .clk(clk), .rst(rst), .fpcsr(fpcsr), .en0(en0), .en1(en1),
  .res0_valid(res0_valid), .res1_valid(res1_valid), .exc_valid(exc_valid)
);

`default_nettype wire

// File: tb_fpu.sv
/* fpu slice testbench */
`timescale 1ns/1ps
`default_nettype none

`include "fpu_config.svh"

module tb_fpu;

  localparam int RST_CYCLES  = 8;
  localparam int SETTLE      = 2;
  localparam int N_ISSUE     = 2000;
  localparam int BURST       = 100;
  localparam int TAG_W       = `FPU_TAG_W;
  localparam int CYCLE_LIMIT = RST_CYCLES + SETTLE + N_ISSUE + `FPU_LAT + 50;

  logic                                  clk, rst;
  logic [31:0]                           fpcsr;
  logic                                  en0, en1;
  fpu_pkg::alu_op_t                      op0;
  fpu_pkg::perm_op_t                     op1;
  logic [`FPU_WORD_W-1:0]                a0, b0, a1, b1;
  fpu_pkg::fwd_src_t                     sel_a0, sel_b0, sel_a1, sel_b1;
  logic [TAG_W-1:0]                      tag0;
  logic [`FPU_NBUS-1:0][`FPU_WORD_W-1:0] fwd_bus;
  logic [`FPU_WORD_W-1:0]                res0, res1;
  logic [3:0]                            res0_flags;
  logic                                  res0_valid, res1_valid, exc_valid;
  logic [TAG_W-1:0]                      exc_tag;

  // buses as driven one cycle before the current ones
  logic [`FPU_NBUS-1:0][`FPU_WORD_W-1:0] bus_old;
  integer                                seed;
  int                                    err_cnt = 0;
  int                                    cycle_cnt = 0;

  // expected outputs, one entry per cycle
  logic                   q_v0[$];
  logic [`FPU_WORD_W-1:0] q_r0[$];
  logic [3:0]             q_f0[$];
  logic                   q_v1[$];
  logic [`FPU_WORD_W-1:0] q_r1[$];
  logic                   q_xv[$];
  logic [TAG_W-1:0]       q_xt[$];

  tb_clk_gen #(.RST_CYCLES(RST_CYCLES)) u_clk (.clk(clk), .rst(rst));

  fpu_slice u_dut (.*);

  function automatic int unsigned rand_below(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // zeros of both signs, NaN or inf exponents, else plain random
  function automatic logic [63:0] rand_word();
    logic [63:0] w;
    w = {$random(seed), $random(seed)};
    case (3'(rand_below(8)))
      3'd0: w = 64'h0;
      3'd1: w = 64'h8000_0000_0000_0000;
      3'd2: w[62:52] = 11'h7ff;
      3'd3: w[30:23] = 8'hff;
      3'd4: w[63:32] = 32'h8000_0000;
      default: ;
    endcase
    return w;
  endfunction

  function automatic fpu_pkg::fwd_src_t rand_sel();
    return fpu_pkg::fwd_src_t'(4'(rand_below(16)));
  endfunction

  function automatic logic [63:0] fwd_pick(fpu_pkg::fwd_src_t sel, logic [63:0] issue_val,
                                           logic [`FPU_NBUS-1:0][63:0] now,
                                           logic [`FPU_NBUS-1:0][63:0] old);
    int code;
    code = int'(sel);
    if (code >= 1 && code <= 4) return now[2'(code - 1)];
    if (code >= 5 && code <= 8) return old[2'(code - 5)];
    return issue_val;
  endfunction

  function automatic logic dbl_nan(logic [63:0] x);
    return x[62:52] == 11'h7ff && x[51:0] != 52'd0;
  endfunction

  function automatic logic sng_nan(logic [31:0] x);
    return x[30:23] == 8'hff && x[22:0] != 23'd0;
  endfunction

  // sign-magnitude onto unsigned order, both zeros land on the midpoint
  function automatic logic [63:0] dbl_key(logic [63:0] x);
    if (x[63]) return 64'h8000_0000_0000_0000 - {1'b0, x[62:0]};
    return 64'h8000_0000_0000_0000 + {1'b0, x[62:0]};
  endfunction

  function automatic logic [31:0] sng_key(logic [31:0] x);
    if (x[31]) return 32'h8000_0000 - {1'b0, x[30:0]};
    return 32'h8000_0000 + {1'b0, x[30:0]};
  endfunction

  task automatic port0_model(input fpu_pkg::alu_op_t op, input logic [63:0] a,
                             input logic [63:0] b, output logic [63:0] res,
                             output logic [3:0] flags, output logic inv);
    logic nan_l;
    int   i;
    res   = '0;
    flags = '0;
    inv   = 1'b0;
    case (op)
      fpu_pkg::ALU_AND:  res = a & b;
      fpu_pkg::ALU_OR:   res = a | b;
      fpu_pkg::ALU_XOR:  res = a ^ b;
      fpu_pkg::ALU_ANDN: res = a & ~b;
      fpu_pkg::ALU_CMP_D: begin
        inv = dbl_nan(a) || dbl_nan(b);
        if (inv) flags = 4'b1000;
        else flags = {1'b0, dbl_key(a) < dbl_key(b), dbl_key(a) == dbl_key(b),
                      dbl_key(a) > dbl_key(b)};
      end
      fpu_pkg::ALU_CMP_SP: begin
        for (i = 0; i < 2; i++) begin
          nan_l = sng_nan(a[32*i +: 32]) || sng_nan(b[32*i +: 32]);
          inv   = inv | nan_l;
          if (!nan_l && sng_key(a[32*i +: 32]) < sng_key(b[32*i +: 32]))
            res[32*i +: 32] = '1;
        end
      end
      default: res = '0;
    endcase
  endtask

  // lane 0 is the low half
  function automatic logic [63:0] perm_model(fpu_pkg::perm_op_t op, logic [63:0] a,
                                             logic [63:0] b);
    case (op)
      fpu_pkg::PERM_MERGE: return {b[63:32], a[31:0]};
      fpu_pkg::PERM_SWAP:  return {a[31:0], a[63:32]};
      fpu_pkg::PERM_DUP:   return {a[31:0], a[31:0]};
      default:             return b;
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      $display("Something failed");
      $fatal(1, "mismatch on %s at %0t", name, $time);
    end
  endtask

  task automatic expect_cycle(input logic v0, input logic [63:0] r0, input logic [3:0] f0,
                              input logic v1, input logic [63:0] r1,
                              input logic xv, input logic [TAG_W-1:0] xt);
    q_v0.push_back(v0);
    q_r0.push_back(r0);
    q_f0.push_back(f0);
    q_v1.push_back(v1);
    q_r1.push_back(r1);
    q_xv.push_back(xv);
    q_xt.push_back(xt);
  endtask

  task automatic check_outputs();
    logic             v0, v1, xv;
    logic [63:0]      r0, r1;
    logic [3:0]       f0;
    logic [TAG_W-1:0] xt;
    v0 = q_v0.pop_front();
    r0 = q_r0.pop_front();
    f0 = q_f0.pop_front();
    v1 = q_v1.pop_front();
    r1 = q_r1.pop_front();
    xv = q_xv.pop_front();
    xt = q_xt.pop_front();
    compare_value("res0_valid", 64'(res0_valid), 64'(v0));
    compare_value("res1_valid", 64'(res1_valid), 64'(v1));
    compare_value("exc_valid", 64'(exc_valid), 64'(xv));
    if (v0) begin
      compare_value("res0", res0, r0);
      compare_value("res0_flags", 64'(res0_flags), 64'(f0));
    end
    if (v1) compare_value("res1", res1, r1);
    if (xv) compare_value("exc_tag", 64'(exc_tag), 64'(xt));
  endtask

  task automatic drive_cycle(input logic issue, input logic burst);
    logic [`FPU_NBUS-1:0][`FPU_WORD_W-1:0] bus_new;
    logic [`FPU_WORD_W-1:0]                oa0, ob0, oa1, ob1, r0;
    logic [3:0]                            f0;
    logic                                  inv0;
    for (int i = 0; i < `FPU_NBUS; i++) begin
      bus_new[i] = rand_word();
    end
    en0     = issue && (burst || rand_below(4) != 0);
    en1     = issue && (burst || rand_below(4) != 0 || !en0);
    op0     = fpu_pkg::alu_op_t'(3'(rand_below(6)));
    op1     = fpu_pkg::perm_op_t'(2'(rand_below(4)));
    a0      = rand_word();
    b0      = (rand_below(8) == 0) ? a0 : rand_word();
    a1      = rand_word();
    b1      = rand_word();
    sel_a0  = rand_sel();
    sel_b0  = rand_sel();
    sel_a1  = rand_sel();
    sel_b1  = rand_sel();
    tag0    = TAG_W'(rand_below(64));
    fpcsr   = $random(seed);
    fwd_bus = bus_new;
    // issue edge samples bus_new, the edge before it sampled bus_old
    oa0 = fwd_pick(sel_a0, a0, bus_new, bus_old);
    ob0 = fwd_pick(sel_b0, b0, bus_new, bus_old);
    oa1 = fwd_pick(sel_a1, a1, bus_new, bus_old);
    ob1 = fwd_pick(sel_b1, b1, bus_new, bus_old);
    port0_model(op0, oa0, ob0, r0, f0, inv0);
    expect_cycle(en0, r0, f0, en1, perm_model(op1, oa1, ob1),
                 en0 && inv0 && fpcsr[`FPU_CSR_INV_EN], tag0);
    bus_old = bus_new;
  endtask

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("Something failed");
      $fatal(1, "run did not finish within %0d cycles", CYCLE_LIMIT);
    end
  end

  initial begin
    seed    = 32'ha0de;
    fpcsr   = '0;
    en0     = 1'b0;
    en1     = 1'b0;
    op0     = fpu_pkg::ALU_AND;
    op1     = fpu_pkg::PERM_MERGE;
    a0      = '0;
    b0      = '0;
    a1      = '0;
    b1      = '0;
    sel_a0  = fpu_pkg::FWD_ISSUE;
    sel_b0  = fpu_pkg::FWD_ISSUE;
    sel_a1  = fpu_pkg::FWD_ISSUE;
    sel_b1  = fpu_pkg::FWD_ISSUE;
    tag0    = '0;
    fwd_bus = '0;
    bus_old = '0;
    // nothing issued in the cycles that reach the outputs first
    repeat (`FPU_LAT) expect_cycle(1'b0, '0, '0, 1'b0, '0, 1'b0, '0);
    @(posedge clk);
    while (rst) begin
      @(negedge clk);
      compare_value("res0_valid", 64'(res0_valid), 64'd0);
      compare_value("res1_valid", 64'(res1_valid), 64'd0);
      compare_value("exc_valid", 64'(exc_valid), 64'd0);
    end
    for (int it = 0; it < SETTLE + N_ISSUE + `FPU_LAT; it++) begin
      @(posedge clk);
      #1;
      check_outputs();
      drive_cycle(it >= SETTLE && it < SETTLE + N_ISSUE, it < SETTLE + BURST);
    end
    if (err_cnt == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Something failed");
      $fatal(1, "%0d checks failed", err_cnt);
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
fpu_pkg.sv
operand_forward.sv
fp_logic_cmp.sv
fp_perm.sv
fpu_excpt.sv
fpu_slice.sv
tb_clk_gen.sv
fpu_chk.sv
tb_fpu.sv

// File: Makefile
# Verilator build and run of the fpu slice testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module tb_fpu -Mdir obj_dir -o tb_fpu

run: compile
	./obj_dir/tb_fpu

clean:
	rm -rf obj_dir
